//--- list.f
hdl/island_pkg.sv
hdl/sram_bank.sv
hdl/main_xbar.sv
hdl/periph_demux.sv
hdl/soc_ctrl_regs.sv
hdl/boot_rom.sv
hdl/island_top.sv
sim/tb_island_top.sv

//--- run.sh
#!/bin/sh
# Build and run the island interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f list.f \
  --top-module tb_island_top \
  -o tb_island_top
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit $status
fi

./obj_dir/tb_island_top
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed"
  exit $status
fi

exit 0

//--- hdl/boot_rom.hex
// Boot ROM image, one 32-bit word per line, word 0 first
00001137
00000093
00000113
000001b3
00000213
00000293
00000313
000003b3
30047073
00001197
80018193
00002117
ff010113
00000517
01450513
30551073
deadbeef
cafef00d
12345678
9abcdef0
0f1e2d3c
4b5a6978
87a5c3e1
5a5aa5a5
00ff00ff
ff00ff00
13579bdf
2468ace0
7fffffff
80000001
10500073
0000006f

//--- sim/tb_island_top.sv
// Testbench for the safety island interconnect
// Drives host and debug ports, predicts every response from a
// reference model and checks it with assertions
module tb_island_top;

  localparam int NumRand = 12;

  // Cycle budget of the test sequence, worst case with contention
  localparam int ResetCycles   = 10;
  localparam int CtrlCycles    = ResetCycles + 2 * 8 + 4;
  localparam int RomCycles     = 2 * (island_pkg::RomNumWords + 2);
  localparam int BankCycles    = 3 * 3 * NumRand;
  localparam int ErrCycles     = 2 * 6;
  localparam int PairCycles    = 3 * 3;
  localparam int PlannedCycles = 2 * CtrlCycles + RomCycles + BankCycles
                                 + ErrCycles + PairCycles;
  localparam int TimeoutCycles = 2 * PlannedCycles;

  typedef struct packed {
    logic        err;
    logic        chk;
    logic [31:0] data;
  } expect_t;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  fetch_enable_i;
  logic                  fetch_enable_o;
  logic [31:0]           boot_addr_o;
  island_pkg::bootmode_e bootmode_i;
  island_pkg::obi_req_t  mgr_req [2];
  island_pkg::obi_rsp_t  host_rsp, dbg_rsp;

  // Reference state
  logic [31:0]           bank0_m [256];
  logic [31:0]           bank1_m [256];
  logic [31:0]           rom_m [island_pkg::RomNumWords];
  logic [31:0]           boot_addr_m;
  logic                  fetchen_m;
  island_pkg::bootmode_e bootmode_m;
  expect_t               exp_q [2];
  logic [31:0]           seed;
  int                    cycle;
  logic [31:0]           rand_addr [2][NumRand];
  logic [3:0]            rand_be [2][NumRand];

  island_top island_top_inst (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .host_req_i     ( mgr_req[0]     ),
    .host_rsp_o     ( host_rsp       ),
    .dbg_req_i      ( mgr_req[1]     ),
    .dbg_rsp_o      ( dbg_rsp        ),
    .bootmode_i     ( bootmode_i     ),
    .fetch_enable_i ( fetch_enable_i ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic wrong_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("MISMATCH %s got %08h expected %08h", name, got, exp);
    stop_run();
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  // 0 bank0, 1 bank1, 2 peripheral region, 3 unmapped
  function automatic int sub_of(input logic [31:0] addr);
    if (addr < 32'h400) return 0;
    if (addr < 32'h800) return 1;
    if (addr >= 32'h1000 && addr < 32'h2000) return 2;
    return 3;
  endfunction

  // Predicts the response of a granted access and updates the model
  task automatic predict(input int m, input logic we, input logic [3:0] be,
                         input logic [31:0] addr, input logic [31:0] wdata);
    expect_t     e;
    logic [31:0] p;
    int          w;
    e = '{err: 1'b1, chk: !we, data: 32'hBADC_AB1E};
    w = int'(addr[9:2]);
    p = addr - 32'h1000;
    if (sub_of(addr) == 0 || sub_of(addr) == 1) begin
      e = '{err: 1'b0, chk: !we, data: (sub_of(addr) == 0) ? bank0_m[w] : bank1_m[w]};
      if (we && sub_of(addr) == 0) bank0_m[w] = merge_bytes(bank0_m[w], wdata, be);
      if (we && sub_of(addr) == 1) bank1_m[w] = merge_bytes(bank1_m[w], wdata, be);
    end else if (sub_of(addr) == 2 && p < 32'h100) begin
      e = '{err: 1'b0, chk: !we, data: 32'h0};
      case (p[7:2])
        6'd0: begin
          e.data = boot_addr_m;
          if (we) boot_addr_m = merge_bytes(boot_addr_m, wdata, be);
        end
        6'd1: begin
          e.data = {31'h0, fetchen_m};
          if (we && be[0]) fetchen_m = wdata[0];
        end
        6'd2: begin
          e.data = {30'h0, bootmode_m};
          e.err  = we;
        end
        default: begin
          e.err = 1'b1;
          e.chk = 1'b0;
        end
      endcase
    end else if (sub_of(addr) == 2 && p >= 32'h100 && p < 32'h180) begin
      e = '{err: we, chk: !we, data: rom_m[p[6:2]]};
    end
    exp_q[m] = e;
  endtask

  // Drives one access on manager m and holds it until granted
  task automatic access(input int m, input logic we, input logic [3:0] be,
                        input logic [31:0] addr, input logic [31:0] wdata, output int gnt_cycle);
    @(posedge clk_i);
    mgr_req[m].req   <= 1'b1;
    mgr_req[m].we    <= we;
    mgr_req[m].be    <= be;
    mgr_req[m].addr  <= addr;
    mgr_req[m].wdata <= wdata;
    @(negedge clk_i);
    while (!((m == 0) ? host_rsp.gnt : dbg_rsp.gnt)) @(negedge clk_i);
    predict(m, we, be, addr, wdata);
    gnt_cycle = cycle;
    @(posedge clk_i);
    mgr_req[m] <= '0;
    @(negedge clk_i);
  endtask

  task automatic apply_reset(input island_pkg::bootmode_e mode);
    @(posedge clk_i);
    rst_ni     <= 1'b0;
    bootmode_i <= mode;
    repeat (8) @(posedge clk_i);
    rst_ni      <= 1'b1;
    boot_addr_m = 32'h1100;
    bootmode_m  = mode;
    fetchen_m   = (mode == island_pkg::Jtag);
    @(posedge clk_i);
  endtask

  task automatic check_fetch_enable();
    for (int v = 0; v < 2; v++) begin
      @(posedge clk_i);
      fetch_enable_i <= 1'(v);
      @(negedge clk_i);
      assert (fetch_enable_o === (fetchen_m | 1'(v)))
        else wrong_value("fetch_enable_o", 32'(fetch_enable_o), 32'(fetchen_m | 1'(v)));
    end
  endtask

  task automatic ctrl_checks(input island_pkg::bootmode_e mode);
    int g;
    apply_reset(mode);
    access(0, 1'b0, 4'hF, 32'h1008, 32'h0, g);
    access(1, 1'b0, 4'hF, 32'h1004, 32'h0, g);
    assert (boot_addr_o === 32'h1100) else wrong_value("boot_addr_o", boot_addr_o, 32'h1100);
    check_fetch_enable();
    seed = xorshift(seed);
    access(0, 1'b1, 4'b0011, 32'h1000, seed, g);
    assert (boot_addr_o === boot_addr_m)
      else wrong_value("boot_addr_o", boot_addr_o, boot_addr_m);
    access(1, 1'b0, 4'hF, 32'h1000, 32'h0, g);
    // Bootmode is read-only and undefined offsets error out
    access(0, 1'b1, 4'hF, 32'h1008, 32'h3, g);
    access(1, 1'b0, 4'hF, 32'h1010, 32'h0, g);
    access(0, 1'b0, 4'hF, 32'h1008, 32'h0, g);
    access(1, 1'b1, 4'h1, 32'h1004, 32'h1, g);
    check_fetch_enable();
  endtask

  task automatic bank_traffic(input int m);
    int g;
    for (int i = 0; i < NumRand; i++) begin
      access(m, 1'b1, 4'hF, rand_addr[m][i], rand_addr[m][i] ^ 32'h5A5A_0000, g);
      access(m, 1'b1, rand_be[m][i], rand_addr[m][i], ~rand_addr[m][i], g);
      access(m, 1'b0, 4'hF, rand_addr[m][i], 32'h0, g);
    end
  endtask

  // ------------------------------------------------------------
  // Checking assertions
  // ------------------------------------------------------------
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_rsp.rvalid && exp_q[0].chk |-> host_rsp.rdata == exp_q[0].data)
    else wrong_value("host_rsp_o.rdata", $sampled(host_rsp.rdata), $sampled(exp_q[0].data));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_rsp.rvalid |-> host_rsp.err == exp_q[0].err)
    else wrong_value("host_rsp_o.err", 32'($sampled(host_rsp.err)),
                     32'($sampled(exp_q[0].err)));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_rsp.rvalid && exp_q[1].chk |-> dbg_rsp.rdata == exp_q[1].data)
    else wrong_value("dbg_rsp_o.rdata", $sampled(dbg_rsp.rdata), $sampled(exp_q[1].data));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_rsp.rvalid |-> dbg_rsp.err == exp_q[1].err)
    else wrong_value("dbg_rsp_o.err", 32'($sampled(dbg_rsp.err)),
                     32'($sampled(exp_q[1].err)));

  // rvalid exactly one cycle after each grant
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_rsp.gnt |=> host_rsp.rvalid)
    else begin
      $display("Host port saw no rvalid one cycle after its grant");
      stop_run();
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_rsp.gnt |=> dbg_rsp.rvalid)
    else begin
      $display("Debug port saw no rvalid one cycle after its grant");
      stop_run();
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_rsp.rvalid |-> $past(host_rsp.gnt))
    else begin
      $display("Host port saw rvalid without a grant in the previous cycle");
      stop_run();
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_rsp.rvalid |-> $past(dbg_rsp.gnt))
    else begin
      $display("Debug port saw rvalid without a grant in the previous cycle");
      stop_run();
    end

  // At most one grant per cycle to any subordinate
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_rsp.gnt && dbg_rsp.gnt |->
      sub_of(mgr_req[0].addr) != sub_of(mgr_req[1].addr) || sub_of(mgr_req[0].addr) == 3)
    else begin
      $display("Both managers granted to the same subordinate in one cycle");
      stop_run();
    end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, a transaction never completed", cycle);
      stop_run();
    end
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    int g0;
    int g1;
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    bootmode_i     = island_pkg::Jtag;
    mgr_req[0]     = '0;
    mgr_req[1]     = '0;
    exp_q[0]       = '0;
    exp_q[1]       = '0;
    cycle          = 0;
    seed           = 32'h2aeeb9fd;
    $readmemh("hdl/boot_rom.hex", rom_m);

    ctrl_checks(island_pkg::Jtag);

    // ROM contents and write rejection
    for (int i = 0; i < island_pkg::RomNumWords; i++) begin
      access(i % 2, 1'b0, 4'hF, 32'h1100 + 32'(4 * i), 32'h0, g0);
    end
    access(0, 1'b1, 4'hF, 32'h1108, 32'hFFFF_FFFF, g0);
    access(1, 1'b0, 4'hF, 32'h1108, 32'h0, g0);

    // Random bank traffic from both managers at once
    for (int m = 0; m < 2; m++) begin
      for (int i = 0; i < NumRand; i++) begin
        seed = xorshift(seed);
        rand_addr[m][i] = {21'h0, seed[8], seed[7:0], 2'b00};
        rand_be[m][i]   = (seed[19:16] == 4'h0) ? 4'h1 : seed[19:16];
      end
    end
    fork
      bank_traffic(0);
      bank_traffic(1);
    join

    // Unmapped addresses and peripheral holes
    access(0, 1'b0, 4'hF, 32'h0000_0800, 32'h0, g0);
    access(1, 1'b1, 4'hF, 32'h0000_0C04, 32'h1, g0);
    access(0, 1'b0, 4'hF, 32'h0000_2000, 32'h0, g0);
    access(1, 1'b0, 4'hF, 32'h8000_0010, 32'h0, g0);
    access(0, 1'b0, 4'hF, 32'h0000_1180, 32'h0, g0);
    access(1, 1'b0, 4'hF, 32'h0000_1FFC, 32'h0, g0);

    // Same bank from both managers, then different targets
    fork
      access(0, 1'b1, 4'hF, 32'h0000_0040, 32'h1111_2222, g0);
      access(1, 1'b1, 4'hF, 32'h0000_0044, 32'h3333_4444, g1);
    join
    fork
      access(0, 1'b0, 4'hF, 32'h0000_0044, 32'h0, g0);
      access(1, 1'b0, 4'hF, 32'h0000_0040, 32'h0, g1);
    join
    fork
      access(0, 1'b0, 4'hF, 32'h0000_0040, 32'h0, g0);
      access(1, 1'b0, 4'hF, 32'h0000_1104, 32'h0, g1);
    join
    assert (g0 == g1) else wrong_value("grant cycle", 32'(g1), 32'(g0));

    ctrl_checks(island_pkg::Default);

    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- hdl/island_top.sv
// Safety island interconnect top level
// Host and debug managers reach two SRAM banks and the peripheral
// region (SoC control registers, boot ROM) through the main crossbar
module island_top #(
  parameter logic [island_pkg::AddrWidth-1:0] BaseAddr     = 32'h0000_0000,
  parameter int unsigned                      BankNumBytes = island_pkg::BankNumBytes
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  island_pkg::obi_req_t            host_req_i,
  output island_pkg::obi_rsp_t            host_rsp_o,
  input  island_pkg::obi_req_t            dbg_req_i,
  output island_pkg::obi_rsp_t            dbg_rsp_o,
  input  island_pkg::bootmode_e           bootmode_i,
  input  logic                            fetch_enable_i,
  output logic                            fetch_enable_o,
  output logic [island_pkg::AddrWidth-1:0] boot_addr_o
);

  localparam logic [island_pkg::AddrWidth-1:0] BootAddrDefault =
      BaseAddr + island_pkg::PeriphOffset + island_pkg::BootRomOffset;

  // Manager 0 is the host, manager 1 the debug port
  island_pkg::obi_rsp_t [1:0] mgr_rsp;

  island_pkg::obi_req_t bank0_req, bank1_req, periph_req;
  island_pkg::obi_rsp_t bank0_rsp, bank1_rsp, periph_rsp;
  island_pkg::obi_req_t ctrl_req, rom_req;
  island_pkg::obi_rsp_t ctrl_rsp, rom_rsp;

  assign host_rsp_o = mgr_rsp[0];
  assign dbg_rsp_o  = mgr_rsp[1];

  main_xbar #(
    .BaseAddr ( BaseAddr )
  ) i_main_xbar (
    .clk_i,
    .rst_ni,
    .mgr_req_i    ( {dbg_req_i, host_req_i} ),
    .mgr_rsp_o    ( mgr_rsp                 ),
    .bank0_req_o  ( bank0_req               ),
    .bank0_rsp_i  ( bank0_rsp               ),
    .bank1_req_o  ( bank1_req               ),
    .bank1_rsp_i  ( bank1_rsp               ),
    .periph_req_o ( periph_req              ),
    .periph_rsp_i ( periph_rsp              )
  );

  sram_bank #(.NumBytes(BankNumBytes)) i_bank0 (
    .clk_i,
    .rst_ni,
    .req_i ( bank0_req ),
    .rsp_o ( bank0_rsp )
  );

  sram_bank #(.NumBytes(BankNumBytes)) i_bank1 (
    .clk_i,
    .rst_ni,
    .req_i ( bank1_req ),
    .rsp_o ( bank1_rsp )
  );

  periph_demux #(
    .BaseAddr ( BaseAddr )
  ) i_periph_demux (
    .clk_i,
    .rst_ni,
    .req_i      ( periph_req ),
    .rsp_o      ( periph_rsp ),
    .ctrl_req_o ( ctrl_req   ),
    .ctrl_rsp_i ( ctrl_rsp   ),
    .rom_req_o  ( rom_req    ),
    .rom_rsp_i  ( rom_rsp    )
  );

  soc_ctrl_regs #(
    .BootAddrDefault ( BootAddrDefault )
  ) i_soc_ctrl (
    .clk_i,
    .rst_ni,
    .req_i          ( ctrl_req       ),
    .rsp_o          ( ctrl_rsp       ),
    .bootmode_i     ( bootmode_i     ),
    .fetch_enable_i ( fetch_enable_i ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  boot_rom i_boot_rom (
    .clk_i,
    .rst_ni,
    .req_i ( rom_req ),
    .rsp_o ( rom_rsp )
  );

endmodule

//--- hdl/boot_rom.sv
// Boot ROM, word table loaded from a hex file
// Reads return one cycle later, writes get an error response
module boot_rom (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  island_pkg::obi_req_t req_i,
  output island_pkg::obi_rsp_t rsp_o
);

  localparam int unsigned IdxWidth = $clog2(island_pkg::RomNumWords);

  logic [island_pkg::DataWidth-1:0] rom [island_pkg::RomNumWords];
  logic [island_pkg::DataWidth-1:0] rdata_q;
  logic [IdxWidth-1:0]              idx;
  logic                             rvalid_q, err_q;

  initial begin
    $readmemh("hdl/boot_rom.hex", rom);
  end

  assign idx = req_i.addr[2 +: IdxWidth];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= rom[idx];
      err_q   <= req_i.we;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = err_q;

endmodule

//--- hdl/soc_ctrl_regs.sv
// SoC control registers
// Boot address, fetch enable and the boot mode captured in the
// first cycle after reset
module soc_ctrl_regs #(
  parameter logic [island_pkg::AddrWidth-1:0] BootAddrDefault = 32'h0000_1100
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  island_pkg::obi_req_t             req_i,
  output island_pkg::obi_rsp_t             rsp_o,
  input  island_pkg::bootmode_e            bootmode_i,
  input  logic                             fetch_enable_i,
  output logic                             fetch_enable_o,
  output logic [island_pkg::AddrWidth-1:0] boot_addr_o
);

  // Word offsets of the registers
  localparam logic [5:0] RegBootAddr = 6'd0;
  localparam logic [5:0] RegFetchEn  = 6'd1;
  localparam logic [5:0] RegBootMode = 6'd2;

  logic [island_pkg::AddrWidth-1:0] boot_addr_q;
  logic                             fetchen_q;
  island_pkg::bootmode_e            bootmode_q;
  logic                             first_cycle_q;
  logic [5:0]                       reg_idx;
  logic [island_pkg::DataWidth-1:0] rdata_d, rdata_q;
  logic                             err_d, err_q, rvalid_q, wr_en;

  assign reg_idx = req_i.addr[7:2];

  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    case (reg_idx)
      RegBootAddr: rdata_d = boot_addr_q;
      RegFetchEn:  rdata_d[0] = fetchen_q;
      RegBootMode: begin
        rdata_d[1:0] = bootmode_q;
        err_d        = req_i.we;
      end
      default: err_d = 1'b1;
    endcase
  end

  assign wr_en = req_i.req && req_i.we && !err_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_cycle_q <= 1'b1;
      boot_addr_q   <= BootAddrDefault;
      fetchen_q     <= 1'b0;
      bootmode_q    <= island_pkg::Default;
      rvalid_q      <= 1'b0;
    end else begin
      first_cycle_q <= 1'b0;
      rvalid_q      <= req_i.req;
      // Hardware capture, a bus write in the same cycle wins
      if (first_cycle_q) begin
        bootmode_q <= bootmode_i;
        fetchen_q  <= (bootmode_i == island_pkg::Jtag);
      end
      if (wr_en && reg_idx == RegBootAddr) begin
        for (int b = 0; b < island_pkg::DataWidth / 8; b++) begin
          if (req_i.be[b]) begin
            boot_addr_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
      if (wr_en && reg_idx == RegFetchEn && req_i.be[0]) begin
        fetchen_q <= req_i.wdata[0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= rdata_d;
      err_q   <= err_d;
    end
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = err_q;

  assign fetch_enable_o = fetchen_q | fetch_enable_i;
  assign boot_addr_o    = boot_addr_q;

  // Capture window opens on reset release and closes one cycle later
  assert property (@(posedge clk_i) $rose(rst_ni) |-> first_cycle_q ##1 !first_cycle_q)
    else $error("first-cycle flag not exactly one cycle");

endmodule

//--- hdl/periph_demux.sv
// Peripheral region demultiplexer
// Steers requests to the SoC control registers or the boot ROM,
// holes inside the region get the error response
module periph_demux #(
  parameter logic [island_pkg::AddrWidth-1:0] BaseAddr = 32'h0000_0000
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  island_pkg::obi_req_t req_i,
  output island_pkg::obi_rsp_t rsp_o,
  output island_pkg::obi_req_t ctrl_req_o,
  input  island_pkg::obi_rsp_t ctrl_rsp_i,
  output island_pkg::obi_req_t rom_req_o,
  input  island_pkg::obi_rsp_t rom_rsp_i
);

  localparam logic [island_pkg::AddrWidth-1:0] PeriphBase = BaseAddr + island_pkg::PeriphOffset;

  typedef enum logic [1:0] {SelCtrl, SelRom, SelErr} sel_e;

  island_pkg::addr_u off;
  sel_e              sel, sel_q;
  logic              gnt, valid_q;

  assign off.flat = req_i.addr - PeriphBase;

  always_comb begin
    if (off.flat - island_pkg::SocCtrlOffset < island_pkg::SocCtrlSize) begin
      sel = SelCtrl;
    end else if (off.flat - island_pkg::BootRomOffset < island_pkg::BootRomSize) begin
      sel = SelRom;
    end else begin
      sel = SelErr;
    end
  end

  // Request path stays combinational
  always_comb begin
    ctrl_req_o     = req_i;
    ctrl_req_o.req = req_i.req && (sel == SelCtrl);
    rom_req_o      = req_i;
    rom_req_o.req  = req_i.req && (sel == SelRom);
    case (sel)
      SelCtrl: gnt = ctrl_rsp_i.gnt;
      SelRom:  gnt = rom_rsp_i.gnt;
      default: gnt = req_i.req;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      sel_q   <= SelErr;
    end else begin
      valid_q <= gnt;
      sel_q   <= sel;
    end
  end

  always_comb begin
    rsp_o     = '0;
    rsp_o.gnt = gnt;
    if (valid_q) begin
      case (sel_q)
        SelCtrl: begin
          rsp_o.rvalid = ctrl_rsp_i.rvalid;
          rsp_o.rdata  = ctrl_rsp_i.rdata;
          rsp_o.err    = ctrl_rsp_i.err;
        end
        SelRom: begin
          rsp_o.rvalid = rom_rsp_i.rvalid;
          rsp_o.rdata  = rom_rsp_i.rdata;
          rsp_o.err    = rom_rsp_i.err;
        end
        default: begin
          rsp_o.rvalid = 1'b1;
          rsp_o.rdata  = island_pkg::ErrRspData;
          rsp_o.err    = 1'b1;
        end
      endcase
    end
  end

endmodule

//--- hdl/main_xbar.sv
// Main crossbar of the safety island
// Two managers, three subordinates plus an internal error response.
// Round-robin arbitration per subordinate on contention
module main_xbar #(
  parameter logic [island_pkg::AddrWidth-1:0] BaseAddr = 32'h0000_0000
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  island_pkg::obi_req_t [1:0] mgr_req_i,
  output island_pkg::obi_rsp_t [1:0] mgr_rsp_o,
  output island_pkg::obi_req_t       bank0_req_o,
  input  island_pkg::obi_rsp_t       bank0_rsp_i,
  output island_pkg::obi_req_t       bank1_req_o,
  input  island_pkg::obi_rsp_t       bank1_rsp_i,
  output island_pkg::obi_req_t       periph_req_o,
  input  island_pkg::obi_rsp_t       periph_rsp_i
);

  localparam int unsigned NumMgr = 2;
  localparam int unsigned NumTgt = 3;

  typedef enum logic [1:0] {TgtBank0, TgtBank1, TgtPeriph, TgtErr} tgt_e;

  tgt_e [NumMgr-1:0]                 tgt;
  logic [NumMgr-1:0]                 gnt;
  tgt_e [NumMgr-1:0]                 sel_q;
  logic [NumMgr-1:0]                 sel_valid_q;
  island_pkg::obi_req_t [NumTgt-1:0] tgt_req;
  island_pkg::obi_rsp_t [NumTgt-1:0] tgt_rsp;
  logic [NumTgt-1:0][NumMgr-1:0]     hit;
  // Winning manager per target, and the manager holding priority
  logic [NumTgt-1:0]                 win;
  logic [NumTgt-1:0]                 rr_q;

  assign bank0_req_o  = tgt_req[TgtBank0];
  assign bank1_req_o  = tgt_req[TgtBank1];
  assign periph_req_o = tgt_req[TgtPeriph];
  assign tgt_rsp      = {periph_rsp_i, bank1_rsp_i, bank0_rsp_i};

  // ------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------
  for (genvar m = 0; m < NumMgr; m++) begin : gen_decode
    island_pkg::addr_u off;

    assign off.flat = mgr_req_i[m].addr - BaseAddr;

    always_comb begin
      tgt[m] = TgtErr;
      if (off.flat < island_pkg::PeriphOffset + island_pkg::PeriphSize) begin
        if (off.fields.region == island_pkg::Bank0Region) begin
          tgt[m] = TgtBank0;
        end else if (off.fields.region == island_pkg::Bank1Region) begin
          tgt[m] = TgtBank1;
        end else if (off.fields.region >= island_pkg::PeriphRegion) begin
          tgt[m] = TgtPeriph;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Per-target arbitration
  // ------------------------------------------------------------
  for (genvar t = 0; t < NumTgt; t++) begin : gen_arb
    for (genvar m = 0; m < NumMgr; m++) begin : gen_hit
      assign hit[t][m] = mgr_req_i[m].req && (tgt[m] == tgt_e'(t));
    end

    assign win[t] = (&hit[t]) ? rr_q[t] : hit[t][1];

    always_comb begin
      tgt_req[t]     = mgr_req_i[win[t]];
      tgt_req[t].req = |hit[t];
    end

    // Loser of a contended grant gets priority next time
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rr_q[t] <= 1'b0;
      end else if ((&hit[t]) && tgt_rsp[t].gnt) begin
        rr_q[t] <= ~win[t];
      end
    end
  end

  // ------------------------------------------------------------
  // Grant and response return
  // ------------------------------------------------------------
  for (genvar m = 0; m < NumMgr; m++) begin : gen_rsp
    always_comb begin
      if (tgt[m] == TgtErr) begin
        // Unmapped addresses are answered here
        gnt[m] = mgr_req_i[m].req;
      end else begin
        gnt[m] = (win[tgt[m]] == 1'(m)) && tgt_rsp[tgt[m]].gnt;
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        sel_valid_q[m] <= 1'b0;
        sel_q[m]       <= TgtErr;
      end else begin
        sel_valid_q[m] <= gnt[m];
        sel_q[m]       <= tgt[m];
      end
    end

    always_comb begin
      mgr_rsp_o[m]     = '0;
      mgr_rsp_o[m].gnt = gnt[m];
      if (sel_valid_q[m]) begin
        if (sel_q[m] == TgtErr) begin
          mgr_rsp_o[m].rvalid = 1'b1;
          mgr_rsp_o[m].rdata  = island_pkg::ErrRspData;
          mgr_rsp_o[m].err    = 1'b1;
        end else begin
          mgr_rsp_o[m].rvalid = tgt_rsp[sel_q[m]].rvalid;
          mgr_rsp_o[m].rdata  = tgt_rsp[sel_q[m]].rdata;
          mgr_rsp_o[m].err    = tgt_rsp[sel_q[m]].err;
        end
      end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
      mgr_rsp_o[m].gnt |-> mgr_req_i[m].req)
      else $error("gnt without req on manager %0d", m);

    // Every subordinate answers exactly one cycle after the grant
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      mgr_rsp_o[m].gnt |=> mgr_rsp_o[m].rvalid)
      else $error("missing rvalid after gnt on manager %0d", m);
  end

endmodule

//--- hdl/sram_bank.sv
// Single-port SRAM bank
// Byte-enabled writes, reads return one cycle after the request
module sram_bank #(
  parameter int unsigned NumBytes = 1024
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  island_pkg::obi_req_t req_i,
  output island_pkg::obi_rsp_t rsp_o
);

  localparam int unsigned NumWords = NumBytes / (island_pkg::DataWidth / 8);
  localparam int unsigned IdxWidth = $clog2(NumWords);

  logic [island_pkg::DataWidth-1:0] mem_q [NumWords];
  logic [island_pkg::DataWidth-1:0] rdata_q;
  logic [IdxWidth-1:0]              idx;
  logic                             rvalid_q;
  island_pkg::addr_u                addr;

  assign addr.flat = req_i.addr;
  assign idx       = req_i.addr[2 +: IdxWidth];

  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.we) begin
      for (int b = 0; b < island_pkg::DataWidth / 8; b++) begin
        if (req_i.be[b]) begin
          mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end else if (req_i.req) begin
      rdata_q <= mem_q[idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o.gnt    = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = 1'b0;

  // Crossbar slots are 1 KiB, a smaller bank must not alias
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i.req |-> 32'(addr.fields.word_idx) < NumWords)
    else $error("word index beyond bank size");

endmodule

//--- hdl/island_pkg.sv
// Safety island interconnect package
// Bus widths, address map, OBI-style request/response structs,
// the address decode union and the boot mode encoding
package island_pkg;

  localparam int unsigned DataWidth = 32;
  localparam int unsigned AddrWidth = 32;

  // Memory sizes
  localparam int unsigned BankNumBytes = 1024;
  localparam int unsigned RomNumWords  = 32;

  // ------------------------------------------------------------
  // Address map, offsets from the island base
  // ------------------------------------------------------------
  localparam logic [AddrWidth-1:0] Bank0Offset  = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] Bank1Offset  = 32'h0000_0400;
  localparam logic [AddrWidth-1:0] PeriphOffset = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] PeriphSize   = 32'h0000_1000;

  // Inside the peripheral region
  localparam logic [AddrWidth-1:0] SocCtrlOffset = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] SocCtrlSize   = 32'h0000_0100;
  localparam logic [AddrWidth-1:0] BootRomOffset = 32'h0000_0100;
  localparam logic [AddrWidth-1:0] BootRomSize   = 32'h0000_0080;

  // Read value of the error response
  localparam logic [DataWidth-1:0] ErrRspData = 32'hBADC_AB1E;

  // Field split of an island-relative address, 1 KiB regions
  localparam int unsigned ByteOffWidth = 2;
  localparam int unsigned WordIdxWidth = 8;
  localparam int unsigned RegionWidth  = 3;
  localparam int unsigned TagWidth     = AddrWidth - RegionWidth - WordIdxWidth - ByteOffWidth;
  localparam int unsigned RegionLsb    = ByteOffWidth + WordIdxWidth;

  localparam logic [RegionWidth-1:0] Bank0Region  = Bank0Offset[RegionLsb +: RegionWidth];
  localparam logic [RegionWidth-1:0] Bank1Region  = Bank1Offset[RegionLsb +: RegionWidth];
  localparam logic [RegionWidth-1:0] PeriphRegion = PeriphOffset[RegionLsb +: RegionWidth];

  typedef enum logic [1:0] {
    Default   = 2'd0,
    Jtag      = 2'd1,
    Preloaded = 2'd2
  } bootmode_e;

  // ------------------------------------------------------------
  // Bus structs
  // ------------------------------------------------------------
  typedef struct packed {
    logic                   req;
    logic                   we;
    logic [DataWidth/8-1:0] be;
    logic [AddrWidth-1:0]   addr;
    logic [DataWidth-1:0]   wdata;
  } obi_req_t;

  typedef struct packed {
    logic                 gnt;
    logic                 rvalid;
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } obi_rsp_t;

  typedef struct packed {
    logic [TagWidth-1:0]     tag;
    logic [RegionWidth-1:0]  region;
    logic [WordIdxWidth-1:0] word_idx;
    logic [ByteOffWidth-1:0] byte_off;
  } addr_fields_t;

  // Flat view for range compares, field view for region decode
  typedef union packed {
    logic [AddrWidth-1:0] flat;
    addr_fields_t         fields;
  } addr_u;

endpackage
